// ==== include/ppu_cfg.svh ====
////////////////////////////////////////
// Build constants for the NES background PPU
// Screen and frame timing, video memory map,
// palette window and CPU register selects.
// Include wherever a constant is needed.
////////////////////////////////////////
`ifndef PPU_CFG_SVH
`define PPU_CFG_SVH

// Screen size and blanking, in pixel clocks and scanlines
`define PPU_NES_W        256
`define PPU_NES_H        240
`define PPU_LINE_LEN     320
`define PPU_FRAME_LINES  262
`define PPU_FETCH_LEAD   8      // Tile fetch runs one tile ahead of display

// Video memory map
`define PPU_NAME_BASE    14'h2000
`define PPU_ATTR_OFFSET  14'h03C0  // Attribute bytes at the end of each name table
`define PPU_PALETTE_PAGE 6'h3F     // Address bits 13:8 of the palette window
`define PPU_PAL_ENTRIES  32

// CPU register selects (0x2000 + sel)
`define PPU_SEL_CTRL0    3'd0
`define PPU_SEL_CTRL1    3'd1
`define PPU_SEL_STATUS   3'd2
`define PPU_SEL_ADDR     3'd6
`define PPU_SEL_DATA     3'd7

// Data port address steps
`define PPU_INCR_ACROSS  14'd1
`define PPU_INCR_DOWN    14'd32

`endif

// ==== logic/ppu_reg_pkg.sv ====
////////////////////////////////////////
// Types of the CPU register side
// Register selects, buffered memory commands,
// control fields and palette writes.
////////////////////////////////////////
`include "ppu_cfg.svh"

package ppu_reg_pkg;

  typedef logic [7:0]  cpu_data_t;   // CPU data byte
  typedef logic [13:0] vram_addr_t;  // Video memory address

  // Register select, low bits of the CPU address
  typedef enum logic [2:0] {
    SEL_CTRL0  = `PPU_SEL_CTRL0,
    SEL_CTRL1  = `PPU_SEL_CTRL1,
    SEL_STATUS = `PPU_SEL_STATUS,
    SEL_ADDR   = `PPU_SEL_ADDR,
    SEL_DATA   = `PPU_SEL_DATA
  } reg_sel_e;

  // Pending data port command, bit 0 valid, bit 1 write
  typedef enum logic [1:0] {
    MEM_NOP   = 2'b00,
    MEM_READ  = 2'b01,
    MEM_WRITE = 2'b11
  } mem_cmd_e;

  // Control fields kept from 0x2000 and 0x2001
  typedef struct packed {
    logic [1:0] nt_sel;     // Name table select
    logic       incr_down;  // Step 32 instead of 1
    logic       bg_table;   // Background pattern table at 0x1000
    logic       nmi_en;     // Pull nvbl low in vblank
    logic       bg_en;      // Show background
  } ctrl_t;

  typedef struct packed {
    logic       we;
    logic [4:0] addr;  // Palette RAM entry
    logic [5:0] data;  // System palette index
  } palette_wr_t;

endpackage

// ==== logic/ppu_video_pkg.sv ====
////////////////////////////////////////
// Types of the video pipeline
// Raster position, tile shifter contents
// and palette indices passed stage to stage.
////////////////////////////////////////
package ppu_video_pkg;

  typedef logic [8:0] coord_t;    // Pixel or line coordinate
  typedef logic [5:0] sys_idx_t;  // System palette index
  typedef logic [3:0] bg_idx_t;   // Background palette index

  // Stage 1 output
  typedef struct packed {
    coord_t x;
    coord_t y;
    logic   visible;  // Inside the 256x240 picture
    logic   vblank;   // Line 240 and beyond
  } raster_pos_t;

  // Stage 2 output, the tile under the current pixel
  typedef struct packed {
    logic [1:0] attr;     // Attribute pair for this tile
    logic [7:0] bit0;     // Pattern plane 0, MSB is leftmost
    logic [7:0] bit1;     // Pattern plane 1
    logic [2:0] fine_x;   // Pixel within the tile
    logic       visible;
  } tile_data_t;

endpackage

// ==== logic/raster_counter.sv ====
`timescale 1ns/10ps
////////////////////////////////////////
// Pipeline stage 1, raster position
// Counts pixel clocks over each line and
// lines over each frame, one step per clock.
////////////////////////////////////////
`include "ppu_cfg.svh"

module raster_counter
  import ppu_video_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  output raster_pos_t pos
);

  coord_t x_q;       // Pixel clock within the line
  coord_t y_q;       // Scanline within the frame
  logic   line_end;

  assign line_end = (x_q == coord_t'(`PPU_LINE_LEN - 1));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      x_q <= '0;
      y_q <= '0;
    end
    else
    begin
      x_q <= line_end ? '0 : x_q + 9'd1;
      if (line_end)
        y_q <= (y_q == coord_t'(`PPU_FRAME_LINES - 1)) ? '0 : y_q + 9'd1;
    end
  end

  assign pos.x       = x_q;
  assign pos.y       = y_q;
  assign pos.visible = (x_q < coord_t'(`PPU_NES_W)) && (y_q < coord_t'(`PPU_NES_H));
  assign pos.vblank  = (y_q >= coord_t'(`PPU_NES_H));  // Bus free for the CPU

  a_x_in_line : assert property (@(posedge clk) disable iff (rst)
    x_q < coord_t'(`PPU_LINE_LEN));

endmodule

// ==== logic/bg_tile_fetch.sv ====
`timescale 1ns/10ps
////////////////////////////////////////
// Pipeline stage 2, background tile fetch
// Reads name, attribute and both pattern
// planes of the next tile in fine x 0..3,
// then loads them at the tile boundary.
////////////////////////////////////////
`include "ppu_cfg.svh"

module bg_tile_fetch
  import ppu_reg_pkg::*;
  import ppu_video_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  raster_pos_t pos,
  input  ctrl_t       ctrl,
  input  cpu_data_t   vram_din,
  output vram_addr_t  fetch_addr,
  output logic        fetch_busy,
  output tile_data_t  tile
);

  logic       line_wrap;   // Tail of hblank, fetch column 0 of next line
  logic       fetch_win;
  coord_t     fetch_row;   // Line whose tile is being fetched
  logic [4:0] fetch_col;   // Tile column being fetched
  cpu_data_t  nxt_name_q;
  cpu_data_t  nxt_attr_q;
  cpu_data_t  nxt_bit0_q;
  cpu_data_t  nxt_bit1_q;
  logic [1:0] nxt_quad_q;  // Quadrant of the next tile in its attribute byte
  tile_data_t tile_q;

  assign line_wrap = (pos.x >= coord_t'(`PPU_LINE_LEN - `PPU_FETCH_LEAD));
  assign fetch_win = (pos.x < coord_t'(`PPU_NES_W - `PPU_FETCH_LEAD)) || line_wrap;
  assign fetch_row = line_wrap ? pos.y + 9'd1 : pos.y;
  assign fetch_col = line_wrap ? 5'd0 : pos.x[7:3] + 5'd1;

  // Bus is ours in the first half of each tile
  assign fetch_busy = ctrl.bg_en && !pos.vblank && fetch_win && !pos.x[2];

  always_comb
  begin
    fetch_addr = '0;
    if (fetch_busy)
      case (pos.x[1:0])
        2'd0: fetch_addr = `PPU_NAME_BASE |
                           {2'b00, ctrl.nt_sel, fetch_row[7:3], fetch_col};
        2'd1: fetch_addr = `PPU_NAME_BASE | `PPU_ATTR_OFFSET |
                           {2'b00, ctrl.nt_sel, 4'h0, fetch_row[7:5], fetch_col[4:2]};
        2'd2: fetch_addr = {1'b0, ctrl.bg_table, nxt_name_q, 1'b0, fetch_row[2:0]};
        default: fetch_addr = {1'b0, ctrl.bg_table, nxt_name_q, 1'b1, fetch_row[2:0]};
      endcase
  end

  // Next-tile bytes, straight off the combinational bus
  always_ff @(posedge clk)
  begin
    if (fetch_busy)
      case (pos.x[1:0])
        2'd0: nxt_name_q <= vram_din;
        2'd1:
        begin
          nxt_attr_q <= vram_din;
          nxt_quad_q <= {fetch_row[4], fetch_col[1]};
        end
        2'd2: nxt_bit0_q <= vram_din;
        default: nxt_bit1_q <= vram_din;
      endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      tile_q <= '0;
    else
    begin
      tile_q.fine_x  <= pos.x[2:0];
      tile_q.visible <= pos.visible;
      // Tile boundary inside the picture
      if ((pos.x[2:0] == 3'd0) && (pos.x < coord_t'(`PPU_NES_W)))
      begin
        tile_q.attr <= nxt_attr_q[{nxt_quad_q, 1'b0} +: 2];
        tile_q.bit0 <= nxt_bit0_q;
        tile_q.bit1 <= nxt_bit1_q;
      end
    end
  end

  assign tile = tile_q;

endmodule

// ==== logic/palette_lookup.sv ====
`timescale 1ns/10ps
////////////////////////////////////////
// Pipeline stage 3, palette lookup
// Holds the 32-entry palette RAM and turns
// the background index into a registered
// system palette index. CPU port reads and
// writes the RAM alongside.
////////////////////////////////////////
`include "ppu_cfg.svh"

module palette_lookup
  import ppu_reg_pkg::*;
  import ppu_video_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  tile_data_t  tile,
  input  logic        bg_en,
  input  palette_wr_t pal_wr,
  input  logic [4:0]  pal_rd_addr,
  output sys_idx_t    pal_rd_data,
  output sys_idx_t    pix_idx,
  output logic        pix_valid
);

  sys_idx_t   pal_ram [`PPU_PAL_ENTRIES];
  logic       px_bit0;
  logic       px_bit1;
  bg_idx_t    bg_idx;
  logic [4:0] lut_addr;

  // Leftmost pixel sits in bit 7
  assign px_bit0 = tile.bit0[3'd7 - tile.fine_x];
  assign px_bit1 = tile.bit1[3'd7 - tile.fine_x];
  assign bg_idx  = {tile.attr, px_bit1, px_bit0};

  // Transparent pixel shows the backdrop entry
  assign lut_addr = (bg_idx[1:0] == 2'b00) ? 5'd0 : {1'b0, bg_idx};

  always_ff @(posedge clk)
  begin
    if (pal_wr.we)
      pal_ram[pal_wr.addr] <= pal_wr.data;
  end

  assign pal_rd_data = pal_ram[pal_rd_addr];  // Feeds the data port read buffer

  always_ff @(posedge clk)
  begin
    pix_idx <= bg_en ? pal_ram[lut_addr] : '0;
    if (rst)
      pix_valid <= 1'b0;
    else
      pix_valid <= tile.visible;
  end

endmodule

// ==== logic/cpu_reg_port.sv ====
`timescale 1ns/10ps
////////////////////////////////////////
// CPU register port
// One access per falling edge of ri_ncs.
// Data port accesses are queued and run
// when the tile fetch leaves the bus free.
////////////////////////////////////////
`include "ppu_cfg.svh"

module cpu_reg_port
  import ppu_reg_pkg::*;
  import ppu_video_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  reg_sel_e    ri_sel,
  input  logic        ri_ncs,
  input  logic        ri_r_nw,
  input  cpu_data_t   ri_din,
  output cpu_data_t   ri_dout,
  input  logic        vblank,
  input  logic        fetch_busy,
  input  cpu_data_t   vram_din,
  output vram_addr_t  ri_addr,
  output cpu_data_t   vram_dout,
  output logic        vram_wr,
  output ctrl_t       ctrl,
  output palette_wr_t pal_wr,
  output logic [4:0]  pal_rd_addr,
  input  sys_idx_t    pal_rd_data,
  output logic        nvbl
);

  logic       ncs_q;        // Last chip select, for edge detect
  logic       access;
  logic       vblank_q;
  logic       vbl_flag_q;   // Status bit 7
  logic       byte_hi_q;    // Next 0x2006 write is the high byte
  vram_addr_t addr_q;       // Data port address
  vram_addr_t addr_incr;
  vram_addr_t addr_buf_q;   // Address of the queued command
  cpu_data_t  wr_buf_q;
  cpu_data_t  rd_buf_q;     // Read buffer behind 0x2007
  cpu_data_t  dout_q;
  mem_cmd_e   cmd_q;
  ctrl_t      ctrl_q;
  logic       grant;
  logic       pal_page;

  assign access    = !ri_ncs && ncs_q;
  assign addr_incr = ctrl_q.incr_down ? `PPU_INCR_DOWN : `PPU_INCR_ACROSS;
  assign grant     = (cmd_q != MEM_NOP) && !fetch_busy;
  assign pal_page  = (addr_buf_q[13:8] == `PPU_PALETTE_PAGE);

  ////////////////////////////////////////
  // Control state
  ////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ncs_q      <= 1'b1;
      vblank_q   <= 1'b0;
      vbl_flag_q <= 1'b0;
      byte_hi_q  <= 1'b1;
      addr_q     <= '0;
      cmd_q      <= MEM_NOP;
      ctrl_q     <= '0;
    end
    else
    begin
      ncs_q    <= ri_ncs;
      vblank_q <= vblank;
      if (vblank && !vblank_q)
        vbl_flag_q <= 1'b1;   // Set on entering vblank
      else if (!vblank)
        vbl_flag_q <= 1'b0;
      if (grant)
        cmd_q <= MEM_NOP;     // Command done this cycle
      if (access && ri_r_nw)
        case (ri_sel)
          SEL_STATUS:
          begin
            vbl_flag_q <= 1'b0;  // Read clears the flag and the byte toggle
            byte_hi_q  <= 1'b1;
          end
          SEL_DATA:
          begin
            cmd_q  <= MEM_READ;
            addr_q <= addr_q + addr_incr;
          end
          default: ;
        endcase
      else if (access)
        case (ri_sel)
          SEL_CTRL0:
          begin
            ctrl_q.nt_sel    <= ri_din[1:0];
            ctrl_q.incr_down <= ri_din[2];
            ctrl_q.bg_table  <= ri_din[4];
            ctrl_q.nmi_en    <= ri_din[7];
          end
          SEL_CTRL1: ctrl_q.bg_en <= ri_din[3];
          SEL_ADDR:
          begin
            if (byte_hi_q)
              addr_q[13:8] <= ri_din[5:0];
            else
              addr_q[7:0] <= ri_din;
            byte_hi_q <= !byte_hi_q;
          end
          SEL_DATA:
          begin
            cmd_q  <= MEM_WRITE;
            addr_q <= addr_q + addr_incr;
          end
          default: ;
        endcase
    end
  end

  ////////////////////////////////////////
  // Data buffers
  ////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (access && (ri_sel == SEL_DATA))
    begin
      addr_buf_q <= addr_q;
      if (!ri_r_nw)
        wr_buf_q <= ri_din;
    end
    // Bus is ours in the grant cycle, so sample it here
    if (grant && (cmd_q == MEM_READ))
      rd_buf_q <= pal_page ? {2'b00, pal_rd_data} : vram_din;
    if (access && ri_r_nw)
      case (ri_sel)
        SEL_STATUS: dout_q <= {vbl_flag_q, 7'd0};
        SEL_DATA:   dout_q <= rd_buf_q;            // Previous read result
        default:    dout_q <= '0;
      endcase
  end

  assign ri_dout     = (!ri_ncs && ri_r_nw) ? dout_q : '0;
  assign ri_addr     = addr_buf_q;
  assign vram_dout   = wr_buf_q;
  assign vram_wr     = grant && (cmd_q == MEM_WRITE) && !pal_page;
  assign pal_wr.we   = grant && (cmd_q == MEM_WRITE) && pal_page;
  assign pal_wr.addr = addr_buf_q[4:0];
  assign pal_wr.data = wr_buf_q[5:0];
  assign pal_rd_addr = addr_buf_q[4:0];
  assign ctrl        = ctrl_q;
  assign nvbl        = !(vblank && ctrl_q.nmi_en);  // Low in vblank when enabled

  // Write strobe lasts one cycle per queued write
  a_wr_single_pulse : assert property (@(posedge clk) disable iff (rst)
    vram_wr |=> !vram_wr);

endmodule

// ==== logic/ppu.sv ====
`timescale 1ns/10ps
////////////////////////////////////////
// Background PPU top level
// Chains raster, tile fetch and palette
// stages; CPU port shares the video bus.
////////////////////////////////////////
module ppu
  import ppu_reg_pkg::*;
  import ppu_video_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  reg_sel_e   ri_sel,
  input  logic       ri_ncs,
  input  logic       ri_r_nw,
  input  cpu_data_t  ri_din,
  output cpu_data_t  ri_dout,
  input  cpu_data_t  vram_din,
  output vram_addr_t vram_a,
  output cpu_data_t  vram_dout,
  output logic       vram_wr,
  output logic       nvbl,
  output sys_idx_t   pix_idx,
  output logic       pix_valid
);

  raster_pos_t pos;
  tile_data_t  tile;
  ctrl_t       ctrl;
  palette_wr_t pal_wr;
  logic [4:0]  pal_rd_addr;
  sys_idx_t    pal_rd_data;
  vram_addr_t  fetch_addr;
  vram_addr_t  ri_addr;
  logic        fetch_busy;

  raster_counter raster_i (
    .clk (clk),
    .rst (rst),
    .pos (pos)
  );

  bg_tile_fetch fetch_i (
    .clk        (clk),
    .rst        (rst),
    .pos        (pos),
    .ctrl       (ctrl),
    .vram_din   (vram_din),
    .fetch_addr (fetch_addr),
    .fetch_busy (fetch_busy),
    .tile       (tile)
  );

  palette_lookup palette_i (
    .clk         (clk),
    .rst         (rst),
    .tile        (tile),
    .bg_en       (ctrl.bg_en),
    .pal_wr      (pal_wr),
    .pal_rd_addr (pal_rd_addr),
    .pal_rd_data (pal_rd_data),
    .pix_idx     (pix_idx),
    .pix_valid   (pix_valid)
  );

  cpu_reg_port regs_i (
    .clk         (clk),
    .rst         (rst),
    .ri_sel      (ri_sel),
    .ri_ncs      (ri_ncs),
    .ri_r_nw     (ri_r_nw),
    .ri_din      (ri_din),
    .ri_dout     (ri_dout),
    .vblank      (pos.vblank),
    .fetch_busy  (fetch_busy),
    .vram_din    (vram_din),
    .ri_addr     (ri_addr),
    .vram_dout   (vram_dout),
    .vram_wr     (vram_wr),
    .ctrl        (ctrl),
    .pal_wr      (pal_wr),
    .pal_rd_addr (pal_rd_addr),
    .pal_rd_data (pal_rd_data),
    .nvbl        (nvbl)
  );

  assign vram_a = fetch_busy ? fetch_addr : ri_addr;  // Fetch has priority

endmodule

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/10ps
////////////////////////////////////////
// Testbench clock and reset
// 100 ns clock, reset high over the
// first four rising edges.
////////////////////////////////////////
module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  initial
  begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    #10;
    rst = 1'b0;  // Released with the other inputs
  end

endmodule

// ==== tests/ppu_tb.sv ====
`timescale 1ns/10ps
////////////////////////////////////////
// Testbench for the background PPU
// Models 16 K of video memory, drives the
// CPU port and checks data port, vblank
// status and background pixels.
////////////////////////////////////////
`include "ppu_cfg.svh"

module ppu_tb
  import ppu_reg_pkg::*;
  import ppu_video_pkg::*;
();

  localparam int DRIVE_DLY   = 10;     // Inputs change after the rising edge
  localparam int ACCESS_GAP  = 12;     // Clocks per CPU access
  localparam int FRAME_LIMIT = 90000;  // Over one frame of clocks
  localparam int VRAM_SIZE   = 16384;
  localparam int LINE0_SKIP  = `PPU_LINE_LEN - 16;  // Past line 0 pixels

  logic        clk;
  logic        rst;
  reg_sel_e    ri_sel;
  logic        ri_ncs;
  logic        ri_r_nw;
  cpu_data_t   ri_din;
  cpu_data_t   ri_dout;
  cpu_data_t   vram_din;
  vram_addr_t  vram_a;
  cpu_data_t   vram_dout;
  logic        vram_wr;
  logic        nvbl;
  sys_idx_t    pix_idx;
  logic        pix_valid;

  cpu_data_t   vram [VRAM_SIZE];  // Video memory model
  logic [31:0] rng;
  logic        pix_check;         // Pixel compare window
  sys_idx_t    bg_color;
  int          pix_count;

  tb_clk_gen clk_gen_i (
    .clk (clk),
    .rst (rst)
  );

  ppu ppu_i (
    .clk       (clk),
    .rst       (rst),
    .ri_sel    (ri_sel),
    .ri_ncs    (ri_ncs),
    .ri_r_nw   (ri_r_nw),
    .ri_din    (ri_din),
    .ri_dout   (ri_dout),
    .vram_din  (vram_din),
    .vram_a    (vram_a),
    .vram_dout (vram_dout),
    .vram_wr   (vram_wr),
    .nvbl      (nvbl),
    .pix_idx   (pix_idx),
    .pix_valid (pix_valid)
  );

  assign vram_din = vram[vram_a];  // Combinational read

  always @(posedge clk)
  begin
    if (vram_wr)
      vram[vram_a] <= vram_dout;
    if (pix_check && pix_valid)
      pix_count <= pix_count + 1;  // Pixels seen in the window
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic expect_equal(input int got, input int exp, input string what);
    assert (got == exp)
    else stop_on_error($sformatf("[FAIL] %0t ns: %s got %0h expected %0h",
                                 $time, what, got, exp));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic cpu_data_t fill_byte(input int a);
    return 8'(a) ^ 8'(a >> 6);  // Every address bit counts
  endfunction

  // One chip select cycle, ACCESS_GAP clocks long
  task automatic cpu_access(input reg_sel_e sel, input logic r_nw,
                            input cpu_data_t din, output cpu_data_t dout);
    @(posedge clk);
    #DRIVE_DLY;
    ri_sel  = sel;
    ri_r_nw = r_nw;
    ri_din  = din;
    ri_ncs  = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    dout = ri_dout;  // Valid two cycles after the edge
    @(posedge clk);
    #DRIVE_DLY;
    ri_ncs  = 1'b1;
    ri_r_nw = 1'b1;
    repeat (ACCESS_GAP - 4) @(posedge clk);
  endtask

  task automatic cpu_write(input reg_sel_e sel, input cpu_data_t din);
    cpu_data_t unused;
    cpu_access(sel, 1'b0, din, unused);
  endtask

  task automatic cpu_read(input reg_sel_e sel, output cpu_data_t dout);
    cpu_access(sel, 1'b1, 8'h00, dout);
  endtask

  task automatic set_vram_addr(input vram_addr_t addr);
    cpu_write(SEL_ADDR, {2'b00, addr[13:8]});  // High byte first
    cpu_write(SEL_ADDR, addr[7:0]);
  endtask

  task automatic wait_nvbl(input logic level);
    int n;
    n = 0;
    @(negedge clk);
    while (nvbl !== level)
    begin
      @(negedge clk);
      n++;
      if (n > FRAME_LIMIT)
        stop_on_error($sformatf("Timeout: nvbl did not reach %b in %0d clocks", level, n));
    end
  endtask

  ////////////////////////////////////////
  // Concurrent checks
  ////////////////////////////////////////
  a_dout_idle : assert property (@(posedge clk) disable iff (rst)
    (ri_ncs || !ri_r_nw) |-> (ri_dout == '0))
    else stop_on_error($sformatf("[FAIL] %0t ns: ri_dout nonzero outside a read", $time));

  a_no_pal_vram_wr : assert property (@(posedge clk) disable iff (rst)
    vram_wr |-> (vram_a[13:8] != `PPU_PALETTE_PAGE))
    else stop_on_error($sformatf("[FAIL] %0t ns: vram_wr pulsed for a palette address", $time));

  a_bg_pixel : assert property (@(posedge clk) disable iff (rst)
    (pix_check && pix_valid) |-> (pix_idx == bg_color))
    else stop_on_error($sformatf("[FAIL] %0t ns: pixel %0h expected %0h",
                                 $time, pix_idx, bg_color));

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial
  begin
    cpu_data_t wr_byte [3];
    cpu_data_t rd_byte;
    cpu_data_t pal_val;
    int        n;
    ri_sel    = SEL_CTRL0;
    ri_ncs    = 1'b1;
    ri_r_nw   = 1'b1;
    ri_din    = '0;
    pix_check = 1'b0;
    bg_color  = '0;
    pix_count = 0;
    rng       = 32'h6cde_7c51;
    for (int a = 0; a < VRAM_SIZE; a++)
      vram[a] = fill_byte(a);

    // Reset values
    n = 0;
    @(negedge clk);
    while (rst)
    begin
      @(negedge clk);
      n++;
      if (n > 20)
        stop_on_error("Timeout: reset was never released");
    end
    expect_equal(nvbl, 1, "nvbl after reset");
    expect_equal(vram_wr, 0, "vram_wr after reset");
    expect_equal(ri_dout, 0, "ri_dout after reset");

    // Writes stepping across
    cpu_write(SEL_CTRL0, 8'h00);
    set_vram_addr(14'h0400);
    for (int i = 0; i < 3; i++)
    begin
      rng = xorshift32(rng);
      wr_byte[i] = rng[7:0];
      cpu_write(SEL_DATA, wr_byte[i]);
    end
    for (int i = 0; i < 3; i++)
      expect_equal(vram[14'h0400 + i], wr_byte[i], "write across");

    // Buffered reads lag by one access
    set_vram_addr(14'h0401);
    cpu_read(SEL_DATA, rd_byte);  // Stale buffer
    cpu_read(SEL_DATA, rd_byte);
    expect_equal(rd_byte, wr_byte[1], "buffered read");
    cpu_read(SEL_DATA, rd_byte);
    expect_equal(rd_byte, wr_byte[2], "buffered read next");

    // Writes stepping down
    cpu_write(SEL_CTRL0, 8'h04);
    set_vram_addr(14'h0800);
    for (int i = 0; i < 3; i++)
    begin
      rng = xorshift32(rng);
      wr_byte[i] = rng[7:0];
      cpu_write(SEL_DATA, wr_byte[i]);
    end
    for (int i = 0; i < 3; i++)
      expect_equal(vram[14'h0800 + `PPU_INCR_DOWN * i], wr_byte[i], "write down");

    // Palette entry 1, 6 bits kept
    cpu_write(SEL_CTRL0, 8'h00);
    rng = xorshift32(rng);
    pal_val = rng[7:0];
    set_vram_addr({`PPU_PALETTE_PAGE, 8'h01});
    cpu_write(SEL_DATA, pal_val);
    expect_equal(vram[14'h3F01], fill_byte(14'h3F01), "memory under palette");
    set_vram_addr({`PPU_PALETTE_PAGE, 8'h01});
    cpu_read(SEL_DATA, rd_byte);
    cpu_read(SEL_DATA, rd_byte);
    expect_equal(rd_byte, {2'b00, pal_val[5:0]}, "palette read back");

    // Vblank interrupt and status flag
    cpu_write(SEL_CTRL0, 8'h80);
    wait_nvbl(1'b1);
    wait_nvbl(1'b0);
    cpu_read(SEL_STATUS, rd_byte);
    expect_equal(rd_byte[7], 1, "status in vblank");
    cpu_read(SEL_STATUS, rd_byte);
    expect_equal(rd_byte[7], 0, "status after read");

    // Solid background, tile 0 pixels all index 1
    for (int a = 0; a < 8; a++)
    begin
      vram[a]     = 8'hFF;  // Plane 0
      vram[a + 8] = 8'h00;  // Plane 1
    end
    for (int a = 14'h2000; a < 14'h2400; a++)
      vram[a] = 8'h00;      // Names and attributes
    bg_color = pal_val[5:0];
    cpu_write(SEL_CTRL1, 8'h08);
    wait_nvbl(1'b1);        // Line 0 starts
    repeat (LINE0_SKIP) @(negedge clk);
    pix_check = 1'b1;
    wait_nvbl(1'b0);
    pix_check = 1'b0;
    expect_equal(pix_count, (`PPU_NES_H - 1) * `PPU_NES_W, "checked pixel count");

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== ppu.f ====
+incdir+include
logic/ppu_reg_pkg.sv
logic/ppu_video_pkg.sv
logic/raster_counter.sv
logic/bg_tile_fetch.sv
logic/palette_lookup.sv
logic/cpu_reg_port.sv
logic/ppu.sv
tests/tb_clk_gen.sv
tests/ppu_tb.sv

// ==== Makefile ====
# Verilator build and run for the background PPU

VERILATOR ?= verilator
TOP       ?= ppu_tb
LINT_TOP  ?= ppu
FILELIST  ?= ppu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "Simulation incomplete"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
